//--- branch_history.sv
/*
  Direct mapped table of 2-bit saturating counters, no tags.
  BhtEntries must be a power of two and at least 2. Aliasing PCs share
  an entry. The lookup is combinational; an update becomes visible to
  the lookup in the cycle after its clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module branch_history #(
    parameter int unsigned BhtEntries = 16
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  fetch_pkg::addr_t    lookup_pc_i,
    output fetch_pkg::bht_cnt_t cnt_o,
    output logic                hit_o,
    input  logic                upd_valid_i,
    input  fetch_pkg::addr_t    upd_pc_i,
    input  logic                upd_taken_i
);

    localparam int unsigned IdxW = $clog2(BhtEntries);

    logic [BhtEntries-1:0] valid_q;
    fetch_pkg::bht_cnt_t   cnt_q [BhtEntries];
    logic [IdxW-1:0]       lookup_idx;
    logic [IdxW-1:0]       upd_idx;
    fetch_pkg::bht_cnt_t   upd_cnt;
    fetch_pkg::bht_cnt_t   cnt_next;

    // word aligned PCs, so index from bit 2 upward
    assign lookup_idx = lookup_pc_i[IdxW+1:2];
    assign upd_idx    = upd_pc_i[IdxW+1:2];

    assign cnt_o   = cnt_q[lookup_idx];
    assign hit_o   = valid_q[lookup_idx];
    assign upd_cnt = cnt_q[upd_idx];

    // new counter value for the resolved branch
    always_comb begin
        if (!valid_q[upd_idx]) begin
            // first sighting, start weakly in the resolved direction
            cnt_next = upd_taken_i ? 2'd2 : 2'd1;
        end else if (upd_taken_i) begin
            cnt_next = (upd_cnt == 2'd3) ? upd_cnt : upd_cnt + 2'd1;
        end else begin
            cnt_next = (upd_cnt == 2'd0) ? upd_cnt : upd_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            cnt_q[upd_idx] <= cnt_next;
        end
    end

endmodule

`default_nettype wire

//--- decoded_if.sv
/*
  One scanned instruction passed from the decoder to the PC generator.
  valid simply follows the memory response strobe, there is no handshake.
  The flags and the immediate hold meaning only while valid is high.
*/
`timescale 1ns/1ps
`default_nettype none

interface decoded_if;

    // response strobe, high for one cycle per returned word
    logic              valid;
    // raw instruction word
    fetch_pkg::instr_t instr;
    // conditional branch found
    logic              is_branch;
    // direct jump found
    logic              is_jal;
    // sign-extended B-type or J-type offset, zero otherwise
    fetch_pkg::addr_t  imm;

    // decoder side
    modport scan (
        output valid, instr, is_branch, is_jal, imm
    );

    // pc generator side
    modport gen (
        input valid, instr, is_branch, is_jal, imm
    );

endinterface

`default_nettype wire

//--- fetch_frontend.sv
/*
  Fetch frontend top: scan, PC generation and fetch queue.
  The instruction memory must return the word one cycle after each
  request, with no back-pressure of its own. A mispredict on the resolve
  port redirects fetch and empties the queue in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter fetch_pkg::addr_t BootAddr   = '0,
    parameter int unsigned      BhtEntries = 16,
    parameter int unsigned      QueueDepth = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // instruction memory
    output logic              imem_req_o,
    output fetch_pkg::addr_t  imem_addr_o,
    input  logic              imem_valid_i,
    input  fetch_pkg::instr_t imem_rdata_i,
    // branch resolution from the back end
    input  logic              resolve_valid_i,
    input  logic              resolve_is_branch_i,
    input  fetch_pkg::addr_t  resolve_pc_i,
    input  logic              resolve_taken_i,
    input  logic              resolve_mispredict_i,
    input  fetch_pkg::addr_t  resolve_target_i,
    // fetched instructions toward the back end
    output logic              fetch_valid_o,
    input  logic              fetch_ready_i,
    output fetch_pkg::addr_t  fetch_pc_o,
    output fetch_pkg::instr_t fetch_instr_o,
    output logic              fetch_taken_o,
    output fetch_pkg::addr_t  fetch_target_o
);

    logic flush;

    decoded_if    dec_if ();
    queue_push_if push_if ();

    instr_scan i_instr_scan (
        .rsp_valid_i (imem_valid_i),
        .rsp_data_i  (imem_rdata_i),
        .dec         (dec_if.scan)
    );

    pc_gen #(
        .BootAddr   (BootAddr),
        .BhtEntries (BhtEntries)
    ) i_pc_gen (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .dec                  (dec_if.gen),
        .push                 (push_if.gen),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_is_branch_i  (resolve_is_branch_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_target_i     (resolve_target_i),
        .imem_req_o           (imem_req_o),
        .imem_addr_o          (imem_addr_o),
        .flush_o              (flush)
    );

    fetch_queue #(
        .QueueDepth (QueueDepth)
    ) i_fetch_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush),
        .push           (push_if.queue),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_ready_i  (fetch_ready_i),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_instr_o  (fetch_instr_o),
        .fetch_taken_o  (fetch_taken_o),
        .fetch_target_o (fetch_target_o)
    );

endmodule

`default_nettype wire

//--- fetch_pkg.sv
/*
  Shared widths and constants of the instruction fetch frontend.
  Only uncompressed RV32 instructions are handled, so every fetch address
  is word aligned and the PC advances by a fixed step of four bytes.
*/
`default_nettype none

package fetch_pkg;

    // --------------------------------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------------------------------

    // byte address of a fetch or of an instruction
    typedef logic [31:0] addr_t;

    // one raw instruction word as returned by the memory
    typedef logic [31:0] instr_t;

    // 2-bit saturating branch counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] bht_cnt_t;

    // --------------------------------------------------------------------------
    // instruction field constants
    // --------------------------------------------------------------------------

    // major opcode of conditional branches (beq, bne, blt, ...)
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // major opcode of jal, the direct jump with a J-type immediate
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // sequential PC step, one 32-bit instruction
    localparam int INSTR_BYTES = 4;

endpackage

`default_nettype wire

//--- fetch_queue.sv
/*
  In-order FIFO of predicted fetch entries toward the back end.
  QueueDepth must be at least 2 and need not be a power of two.
  flush_i empties the queue at the next edge and wins over a push.
  An entry is visible at fetch_valid_o one cycle after its push.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int unsigned QueueDepth = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    queue_push_if.queue       push,
    output logic              fetch_valid_o,
    input  logic              fetch_ready_i,
    output fetch_pkg::addr_t  fetch_pc_o,
    output fetch_pkg::instr_t fetch_instr_o,
    output logic              fetch_taken_o,
    output fetch_pkg::addr_t  fetch_target_o
);

    localparam int unsigned PtrW = $clog2(QueueDepth);
    localparam int unsigned CntW = $clog2(QueueDepth + 1);

    // entry storage
    fetch_pkg::addr_t  pc_mem     [QueueDepth];
    fetch_pkg::instr_t instr_mem  [QueueDepth];
    fetch_pkg::addr_t  target_mem [QueueDepth];
    logic [QueueDepth-1:0] taken_mem;

    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic            pop;

    // wrap at QueueDepth, not at the pointer width
    function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(QueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign fetch_valid_o = (count_q != '0);
    assign push.full     = (count_q == CntW'(QueueDepth));
    assign pop           = fetch_valid_o && fetch_ready_i;

    // head of queue
    assign fetch_pc_o     = pc_mem[rd_ptr_q];
    assign fetch_instr_o  = instr_mem[rd_ptr_q];
    assign fetch_taken_o  = taken_mem[rd_ptr_q];
    assign fetch_target_o = target_mem[rd_ptr_q];

    // --------------------------------------------------------------------------
    // pointers and fill level
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push.push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // simultaneous push and pop keep the level
            if (push.push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push.push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push.push) begin
            pc_mem[wr_ptr_q]     <= push.pc;
            instr_mem[wr_ptr_q]  <= push.instr;
            taken_mem[wr_ptr_q]  <= push.taken;
            target_mem[wr_ptr_q] <= push.target;
        end
    end

    count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= CntW'(QueueDepth))
        else $error("fetch queue level above its depth");

endmodule

`default_nettype wire

//--- instr_scan.sv
/*
  Pure combinational scan of one returned word for control flow.
  Only conditional branches and jal are recognised; jalr and all other
  opcodes report no flag and a zero immediate. The word is assumed to be
  a 32-bit instruction, compressed encodings are not looked at.
*/
`timescale 1ns/1ps
`default_nettype none

module instr_scan (
    input  logic              rsp_valid_i,
    input  fetch_pkg::instr_t rsp_data_i,
    decoded_if.scan           dec
);

    logic [6:0]       opcode;
    fetch_pkg::addr_t b_imm;
    fetch_pkg::addr_t j_imm;

    assign opcode = rsp_data_i[6:0];

    // --------------------------------------------------------------------------
    // immediate assembly
    // --------------------------------------------------------------------------

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm = {{20{rsp_data_i[31]}}, rsp_data_i[7], rsp_data_i[30:25],
                    rsp_data_i[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {{12{rsp_data_i[31]}}, rsp_data_i[19:12], rsp_data_i[20],
                    rsp_data_i[30:21], 1'b0};

    // --------------------------------------------------------------------------
    // classification
    // --------------------------------------------------------------------------

    // strobe and word pass straight through
    assign dec.valid = rsp_valid_i;
    assign dec.instr = rsp_data_i;

    assign dec.is_branch = (opcode == fetch_pkg::OPC_BRANCH);
    assign dec.is_jal    = (opcode == fetch_pkg::OPC_JAL);

    always_comb begin
        if (dec.is_branch) begin
            dec.imm = b_imm;
        end else if (dec.is_jal) begin
            dec.imm = j_imm;
        end else begin
            // no control flow, keep the offset quiet
            dec.imm = '0;
        end
    end

endmodule

`default_nettype wire

//--- pc_gen.sv
/*
  Next PC selection with static and history based branch prediction.
  Assumes the memory answers every request exactly one cycle later, so at
  most one request is outstanding. JALR is not predicted and falls through.
  A response that meets a full queue is dropped and its address refetched.
*/
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter fetch_pkg::addr_t BootAddr   = '0,
    parameter int unsigned      BhtEntries = 16
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    decoded_if.gen           dec,
    queue_push_if.gen        push,
    input  logic             resolve_valid_i,
    input  logic             resolve_is_branch_i,
    input  fetch_pkg::addr_t resolve_pc_i,
    input  logic             resolve_taken_i,
    input  logic             resolve_mispredict_i,
    input  fetch_pkg::addr_t resolve_target_i,
    output logic             imem_req_o,
    output fetch_pkg::addr_t imem_addr_o,
    output logic             flush_o
);

    fetch_pkg::addr_t    npc_q;
    fetch_pkg::addr_t    req_addr_q;
    fetch_pkg::addr_t    pred_target;
    logic                first_q;
    logic                req_q;
    logic                rsp_valid;
    logic                mispredict;
    logic                pred_taken;
    logic                bht_hit;
    fetch_pkg::bht_cnt_t bht_cnt;

    // lookup is keyed by the address whose word is coming back
    branch_history #(
        .BhtEntries (BhtEntries)
    ) i_branch_history (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_pc_i (req_addr_q),
        .cnt_o       (bht_cnt),
        .hit_o       (bht_hit),
        .upd_valid_i (resolve_valid_i && resolve_is_branch_i),
        .upd_pc_i    (resolve_pc_i),
        .upd_taken_i (resolve_taken_i)
    );

    assign mispredict = resolve_valid_i && resolve_mispredict_i;
    assign flush_o    = mispredict;
    // ignore strobes for requests made while in reset
    assign rsp_valid  = dec.valid && req_q;

    // --------------------------------------------------------------------------
    // prediction
    // --------------------------------------------------------------------------

    always_comb begin
        if (dec.is_jal) begin
            pred_taken = 1'b1;
        end else if (dec.is_branch) begin
            // history first, else backward taken and forward not taken
            pred_taken = bht_hit ? (bht_cnt >= 2'd2) : dec.imm[31];
        end else begin
            pred_taken = 1'b0;
        end
    end

    assign pred_target = pred_taken ? req_addr_q + dec.imm
                       : req_addr_q + fetch_pkg::addr_t'(fetch_pkg::INSTR_BYTES);

    // --------------------------------------------------------------------------
    // address selection
    // --------------------------------------------------------------------------

    // no request while full, the address is then only held in npc_q
    // a redirect still requests, the queue is empty again at the next edge
    assign imem_req_o = !push.full || mispredict;

    always_comb begin
        if (mispredict) begin
            imem_addr_o = resolve_target_i;
        end else if (rsp_valid && push.full) begin
            // replay, the word could not be queued
            imem_addr_o = req_addr_q;
        end else if (rsp_valid) begin
            imem_addr_o = pred_target;
        end else if (first_q) begin
            imem_addr_o = BootAddr;
        end else begin
            imem_addr_o = npc_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            first_q <= 1'b1;
            req_q   <= 1'b0;
        end else begin
            first_q <= 1'b0;
            req_q   <= imem_req_o;
        end
    end

    always_ff @(posedge clk_i) begin
        npc_q <= imem_addr_o;
        if (imem_req_o) begin
            req_addr_q <= imem_addr_o;
        end
    end

    // queue write, the response is dropped on a redirect
    assign push.push   = rsp_valid && !push.full && !mispredict;
    assign push.pc     = req_addr_q;
    assign push.instr  = dec.instr;
    assign push.taken  = pred_taken;
    assign push.target = pred_target;

    // the memory must answer each request in the following cycle
    mem_answers_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        imem_req_o |=> dec.valid)
        else $error("instruction memory missed its response cycle");

endmodule

`default_nettype wire

//--- project.f
fetch_pkg.sv
decoded_if.sv
queue_push_if.sv
instr_scan.sv
branch_history.sv
pc_gen.sv
fetch_queue.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- queue_push_if.sv
/*
  Write port of the fetch queue, driven by the PC generator.
  The producer must keep push low while full is high; the queue does not
  check this and would overwrite its oldest entry.
*/
`timescale 1ns/1ps
`default_nettype none

interface queue_push_if;

    // write strobe, one entry per cycle at most
    logic              push;
    // address of the fetched instruction
    fetch_pkg::addr_t  pc;
    // fetched instruction word
    fetch_pkg::instr_t instr;
    // prediction made for this instruction
    logic              taken;
    // predicted next PC, pc + 4 when not taken
    fetch_pkg::addr_t  target;
    // queue level, high when no slot is free
    logic              full;

    // pc generator side
    modport gen (
        output push, pc, instr, taken, target,
        input  full
    );

    // queue side
    modport queue (
        input  push, pc, instr, taken, target,
        output full
    );

endinterface

`default_nettype wire

//--- tb_fetch_frontend.sv
/*
  Testbench for the fetch frontend. A word array memory holds a short
  program at 0x100 and answers every request one cycle later. Filler is
  returned outside the program. Expected entries come from a reference
  predictor with its own copy of the history counters, and a watchdog
  bounds the run time.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    localparam fetch_pkg::addr_t BOOT_ADDR = 32'h0000_0100;
    localparam int CLK_PERIOD  = 8;
    localparam int BHT_ENTRIES = 16;
    localparam int PROG_WORDS  = 14;

    // entries delivered per test stage
    localparam int N_SEQ     = 3;
    localparam int N_STATIC  = 17;
    localparam int N_RANDOM  = 24;
    localparam int N_PRE     = 10;
    localparam int N_TRAIN   = 8;
    localparam int N_RETRAIN = 8;
    localparam int TOTAL_ENTRIES = N_SEQ + N_STATIC + N_RANDOM + N_PRE + N_TRAIN + N_RETRAIN;

    typedef struct packed {
        fetch_pkg::addr_t  pc;
        fetch_pkg::instr_t instr;
        logic              taken;
        fetch_pkg::addr_t  target;
    } entry_t;

    logic              clk_i;
    logic              rst_ni;
    logic              imem_req_o;
    fetch_pkg::addr_t  imem_addr_o;
    logic              imem_valid_i;
    fetch_pkg::instr_t imem_rdata_i;
    logic              resolve_valid_i;
    logic              resolve_is_branch_i;
    fetch_pkg::addr_t  resolve_pc_i;
    logic              resolve_taken_i;
    logic              resolve_mispredict_i;
    fetch_pkg::addr_t  resolve_target_i;
    logic              fetch_valid_o;
    logic              fetch_ready_i;
    fetch_pkg::addr_t  fetch_pc_o;
    fetch_pkg::instr_t fetch_instr_o;
    logic              fetch_taken_o;
    fetch_pkg::addr_t  fetch_target_o;

    fetch_pkg::instr_t   prog [PROG_WORDS];
    // reference copy of the history table
    logic                bht_valid [BHT_ENTRIES];
    fetch_pkg::bht_cnt_t bht_cnt   [BHT_ENTRIES];
    entry_t              exp_q [$];
    fetch_pkg::addr_t    walk_pc;
    logic [31:0]         lcg_state;
    string               cur_test;
    int                  errors;
    int                  checks;
    int                  xfer_count;

    fetch_frontend #(
        .BootAddr   (BOOT_ADDR),
        .BhtEntries (BHT_ENTRIES),
        .QueueDepth (4)
    ) dut0 (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .imem_req_o           (imem_req_o),
        .imem_addr_o          (imem_addr_o),
        .imem_valid_i         (imem_valid_i),
        .imem_rdata_i         (imem_rdata_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_is_branch_i  (resolve_is_branch_i),
        .resolve_pc_i         (resolve_pc_i),
        .resolve_taken_i      (resolve_taken_i),
        .resolve_mispredict_i (resolve_mispredict_i),
        .resolve_target_i     (resolve_target_i),
        .fetch_valid_o        (fetch_valid_o),
        .fetch_ready_i        (fetch_ready_i),
        .fetch_pc_o           (fetch_pc_o),
        .fetch_instr_o        (fetch_instr_o),
        .fetch_taken_o        (fetch_taken_o),
        .fetch_target_o       (fetch_target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------------------------------
    // instruction encoders and program image
    // --------------------------------------------------------------------------

    function automatic fetch_pkg::instr_t enc_addi(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic fetch_pkg::instr_t enc_branch(input logic [2:0] funct3,
                                                     input logic [4:0] rs1,
                                                     input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], rs2, rs1, funct3, o[4:1], o[11], fetch_pkg::OPC_BRANCH};
    endfunction

    function automatic fetch_pkg::instr_t enc_jal(input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, fetch_pkg::OPC_JAL};
    endfunction

    task automatic load_program();
        prog[0]  = enc_addi(5'd1, 12'd1);
        prog[1]  = enc_addi(5'd2, 12'd2);
        prog[2]  = enc_addi(5'd3, 12'd3);
        // 0x10c jumps over two words to the loop head
        prog[3]  = enc_jal(12);
        prog[4]  = enc_addi(5'd31, 12'd31);
        prog[5]  = enc_addi(5'd30, 12'd30);
        // loop head at 0x118
        prog[6]  = enc_addi(5'd5, 12'd1);
        // forward exit to 0x12c
        prog[7]  = enc_branch(3'b000, 5'd5, 5'd6, 16);
        prog[8]  = enc_addi(5'd7, 12'd1);
        // backward edge to 0x118
        prog[9]  = enc_branch(3'b001, 5'd0, 5'd1, -12);
        prog[10] = enc_addi(5'd29, 12'd29);
        // exit block, jumps back to the loop head
        prog[11] = enc_addi(5'd8, 12'd8);
        prog[12] = enc_jal(-24);
        prog[13] = enc_addi(5'd28, 12'd28);
    endtask

    // filler is an addi whose fields mix all address bits
    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
        if (addr >= BOOT_ADDR && addr < BOOT_ADDR + 4 * PROG_WORDS) begin
            return prog[int'((addr - BOOT_ADDR) >> 2)];
        end
        return {addr[31:7] ^ addr[24:0], 7'b0010011};
    endfunction

    // --------------------------------------------------------------------------
    // reference predictor
    // --------------------------------------------------------------------------

    function automatic fetch_pkg::addr_t offset_of(input fetch_pkg::instr_t w);
        if (w[6:0] == fetch_pkg::OPC_BRANCH) begin
            return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        if (w[6:0] == fetch_pkg::OPC_JAL) begin
            return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        return '0;
    endfunction

    function automatic logic predict_taken(input fetch_pkg::addr_t pc,
                                           input fetch_pkg::instr_t w);
        int               idx;
        fetch_pkg::addr_t off;
        idx = int'((pc >> 2) % BHT_ENTRIES);
        off = offset_of(w);
        if (w[6:0] == fetch_pkg::OPC_JAL) begin
            return 1'b1;
        end
        if (w[6:0] == fetch_pkg::OPC_BRANCH) begin
            // counter wins over the sign of the offset
            if (bht_valid[idx]) begin
                return bht_cnt[idx] >= 2'd2;
            end
            return off[31];
        end
        return 1'b0;
    endfunction

    function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t pc,
                                                 input fetch_pkg::instr_t w);
        if (predict_taken(pc, w)) begin
            return pc + offset_of(w);
        end
        return pc + 32'd4;
    endfunction

    task automatic bht_train(input fetch_pkg::addr_t pc, input logic taken);
        int idx;
        idx = int'((pc >> 2) % BHT_ENTRIES);
        if (!bht_valid[idx]) begin
            bht_valid[idx] = 1'b1;
            bht_cnt[idx]   = taken ? 2'd2 : 2'd1;
        end else if (taken && bht_cnt[idx] != 2'd3) begin
            bht_cnt[idx] = bht_cnt[idx] + 2'd1;
        end else if (!taken && bht_cnt[idx] != 2'd0) begin
            bht_cnt[idx] = bht_cnt[idx] - 2'd1;
        end
    endtask

    // extend the expected stream by n entries from walk_pc
    task automatic build_expected(input int n);
        entry_t e;
        for (int i = 0; i < n; i++) begin
            e.pc     = walk_pc;
            e.instr  = mem_word(walk_pc);
            e.taken  = predict_taken(walk_pc, e.instr);
            e.target = next_pc(walk_pc, e.instr);
            exp_q.push_back(e);
            walk_pc = e.target;
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------------------------------------------
    // memory model and compare process
    // --------------------------------------------------------------------------

    initial begin
        logic             req_s;
        fetch_pkg::addr_t addr_s;
        imem_valid_i = 1'b0;
        imem_rdata_i = '0;
        forever begin
            // request is stable mid cycle, answer just after the next edge
            @(negedge clk_i);
            req_s  = (imem_req_o === 1'b1);
            addr_s = imem_addr_o;
            @(posedge clk_i);
            #1;
            imem_valid_i = req_s;
            imem_rdata_i = req_s ? mem_word(addr_s) : '0;
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    initial begin
        entry_t e;
        forever begin
            // a transfer seen here completes at the next rising edge
            @(negedge clk_i);
            if (rst_ni && fetch_valid_o && fetch_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error in %s: back end got pc %h with no entry expected",
                             cur_test, fetch_pc_o);
                end else begin
                    e = exp_q.pop_front();
                    check_value("pc", e.pc, fetch_pc_o);
                    check_value("instr", e.instr, fetch_instr_o);
                    check_value("taken", 32'(e.taken), 32'(fetch_taken_o));
                    check_value("target", e.target, fetch_target_o);
                end
                xfer_count++;
            end
        end
    end

    initial begin
        #(20 * TOTAL_ENTRIES * CLK_PERIOD);
        $display("timeout: run did not finish in time, stuck in test %s", cur_test);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------

    task automatic apply_reset();
        rst_ni        = 1'b0;
        fetch_ready_i = 1'b0;
        exp_q.delete();
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            bht_valid[i] = 1'b0;
        end
        walk_pc = BOOT_ADDR;
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
    endtask

    // deliver n more entries, ready held high or drawn from the LCG
    task automatic run_stream(input int n, input logic random_ready);
        int target;
        build_expected(n);
        target = xfer_count + n;
        do begin
            @(posedge clk_i);
            #1;
            if (xfer_count < target) begin
                if (random_ready) begin
                    lcg_state     = lcg_next(lcg_state);
                    fetch_ready_i = lcg_state[20];
                end else begin
                    fetch_ready_i = 1'b1;
                end
            end
        end while (xfer_count < target);
        fetch_ready_i = 1'b0;
    endtask

    // request strobe drops once the queue is full
    task automatic wait_queue_full();
        do begin
            @(negedge clk_i);
        end while (imem_req_o !== 1'b0);
    endtask

    task automatic send_resolve(input fetch_pkg::addr_t pc, input logic taken,
                                input fetch_pkg::addr_t target);
        @(posedge clk_i);
        #1;
        resolve_valid_i      = 1'b1;
        resolve_is_branch_i  = 1'b1;
        resolve_pc_i         = pc;
        resolve_taken_i      = taken;
        resolve_mispredict_i = 1'b1;
        resolve_target_i     = target;
        // queued entries are flushed, the stream restarts at the target
        exp_q.delete();
        bht_train(pc, taken);
        walk_pc = target;
        @(posedge clk_i);
        #1;
        resolve_valid_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_mispredict_i = 1'b0;
    endtask

    initial begin
        fetch_ready_i        = 1'b0;
        resolve_valid_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_pc_i         = '0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = '0;
        errors     = 0;
        checks     = 0;
        xfer_count = 0;
        lcg_state  = 32'd36;
        cur_test   = "reset";
        load_program();
        apply_reset();

        // first request goes to the boot address
        @(negedge clk_i);
        check_value("fetch_valid_o", 32'd0, 32'(fetch_valid_o));
        while (imem_req_o !== 1'b1) begin
            @(negedge clk_i);
        end
        check_value("imem_addr_o", BOOT_ADDR, imem_addr_o);

        cur_test = "sequential";
        run_stream(N_SEQ, 1'b0);
        cur_test = "static";
        run_stream(N_STATIC, 1'b0);

        cur_test = "backpressure";
        apply_reset();
        run_stream(N_RANDOM, 1'b1);

        // forward branch at 0x11c resolved taken, later resolved not taken
        cur_test = "resolve";
        apply_reset();
        run_stream(N_PRE, 1'b0);
        wait_queue_full();
        send_resolve(32'h0000_011C, 1'b1, 32'h0000_012C);
        run_stream(N_TRAIN, 1'b0);
        wait_queue_full();
        send_resolve(32'h0000_011C, 1'b0, 32'h0000_0120);
        run_stream(N_RETRAIN, 1'b0);

        repeat (2) @(posedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
